// File: dmix_pkg.sv
package dmix_pkg;

    // One audio sample, two's complement, MSB first on the wire
    typedef logic [23:0] sample_t;

    // Stereo frame with the left sample in the upper half
    typedef logic [2*$bits(sample_t)-1:0] frame_t;

    // Time slots per S/PDIF subframe, preamble included
    localparam int SUBFRAME_BITS = 32;

    // Bit clocks per I2S channel slot
    localparam int SLOT_BITS = 32;

    // Clocks between two biphase transitions
    typedef logic [4:0] pulse_cnt_t;

    // Subframe preambles
    // B opens a block and carries left, M carries left, W carries right
    typedef enum logic [1:0] {
        PRE_B,
        PRE_M,
        PRE_W
    } preamble_t;

endpackage

// File: spdif_decoder.sv
`timescale 1ns/100ps

module spdif_decoder #(
    parameter int CELL_CLKS  = 4,
    parameter int LOCK_COUNT = 8
) (
    input  logic              clk245760,
    input  logic              rst,
    input  logic              spdif_i,
    output dmix_pkg::sample_t sample_o,
    output logic              right_o,
    output logic              valid_o,
    output logic              locked_o
);
    import dmix_pkg::*;

    // Slots 4..31 carry aux, audio, V, U, C and P
    localparam int DATA_BITS = SUBFRAME_BITS - 4;
    localparam int BIT_CNT_W = $clog2(DATA_BITS);
    localparam int LOCK_W    = $clog2(LOCK_COUNT + 1);
    localparam int HALF      = CELL_CLKS / 2;

    // Width windows, half a cell either side of 1, 2 and 3 cells
    localparam pulse_cnt_t W1_MIN  = pulse_cnt_t'(HALF);
    localparam pulse_cnt_t W2_MIN  = pulse_cnt_t'(CELL_CLKS + HALF);
    localparam pulse_cnt_t W3_MIN  = pulse_cnt_t'(2 * CELL_CLKS + HALF);
    localparam pulse_cnt_t W3_MAX  = pulse_cnt_t'(3 * CELL_CLKS + HALF);
    localparam pulse_cnt_t TIMEOUT = pulse_cnt_t'(4 * CELL_CLKS);

    typedef enum logic [1:0] {
        ST_HUNT,
        ST_PRE,
        ST_DATA
    } state_t;

    logic [2:0]           sync_q;
    logic                 edge_det;
    pulse_cnt_t           width_q;
    logic [1:0]           cells;
    logic                 timeout;

    state_t               state_q;
    logic [1:0]           pre_cnt_q;
    logic [3:0]           pre_w_q;
    preamble_t            pre_type_q;
    preamble_t            pre_kind;
    logic                 pre_hit;
    logic                 pre_bad;
    logic                 half_q;
    logic                 par_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    logic [DATA_BITS-1:0] shreg_q;
    logic [DATA_BITS-1:0] shift_next;
    logic [LOCK_W-1:0]    good_cnt_q;
    logic                 bit_done;
    logic                 bit_val;
    logic                 viol;
    logic                 last_bit;
    logic                 frame_end;
    logic                 par_ok;
    logic                 drop;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk245760) begin
        if (rst) begin
            sync_q  <= '0;
            width_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], spdif_i};
            if (edge_det) begin
                width_q <= pulse_cnt_t'(1);
            end else if (width_q != TIMEOUT) begin
                width_q <= width_q + 1'b1;
            end
        end
    end

    assign edge_det = sync_q[2] ^ sync_q[1];
    assign timeout  = (width_q == TIMEOUT) && !edge_det;

    // Pulse width in cells, 0 for a width outside every window
    always_comb begin
        if (width_q < W1_MIN) begin
            cells = 2'd0;
        end else if (width_q < W2_MIN) begin
            cells = 2'd1;
        end else if (width_q < W3_MIN) begin
            cells = 2'd2;
        end else if (width_q < W3_MAX) begin
            cells = 2'd3;
        end else begin
            cells = 2'd0;
        end
    end

    // Pulses 2..4 of a preamble: B is 1-1-3, M is 3-1-1, W is 2-1-2
    always_comb begin
        pre_hit  = 1'b1;
        pre_kind = PRE_B;
        case ({pre_w_q, cells})
            6'b01_01_11: pre_kind = PRE_B;
            6'b11_01_01: pre_kind = PRE_M;
            6'b10_01_10: pre_kind = PRE_W;
            default:     pre_hit = 1'b0;
        endcase
    end

    assign pre_bad = (pre_cnt_q == 2'd0 && cells != 2'd3) || (pre_cnt_q == 2'd3 && !pre_hit);

    // A 2-cell pulse is a zero, two 1-cell pulses make a one
    always_comb begin
        bit_done = 1'b0;
        bit_val  = 1'b0;
        viol     = 1'b0;
        if (edge_det) begin
            case (cells)
                2'd1: begin
                    bit_done = half_q;
                    bit_val  = 1'b1;
                end
                2'd2: begin
                    bit_done = 1'b1;
                    viol     = half_q;
                end
                default: viol = 1'b1;
            endcase
        end
    end

    // Bits arrive LSB first, so they enter at the top
    assign shift_next = {bit_val, shreg_q[DATA_BITS-1:1]};
    assign last_bit   = bit_cnt_q == BIT_CNT_W'(DATA_BITS - 1);
    assign frame_end  = bit_done && !viol && last_bit;
    assign par_ok     = !(par_q ^ bit_val);

    always_comb begin
        case (state_q)
            ST_PRE:  drop = edge_det && pre_bad;
            ST_DATA: drop = viol || (frame_end && !par_ok);
            default: drop = 1'b0;
        endcase
        drop = drop || timeout;
    end

    always_ff @(posedge clk245760) begin
        valid_o <= 1'b0;
        if (rst) begin
            state_q    <= ST_HUNT;
            pre_cnt_q  <= '0;
            half_q     <= 1'b0;
            par_q      <= 1'b0;
            bit_cnt_q  <= '0;
            good_cnt_q <= '0;
            locked_o   <= 1'b0;
        end else if (drop) begin
            state_q    <= ST_HUNT;
            good_cnt_q <= '0;
            locked_o   <= 1'b0;
        end else if (edge_det) begin
            case (state_q)
                ST_HUNT: begin
                    // Only a preamble holds a 3-cell pulse
                    if (cells == 2'd3) begin
                        state_q   <= ST_PRE;
                        pre_cnt_q <= 2'd1;
                    end
                end
                ST_PRE: begin
                    pre_cnt_q <= pre_cnt_q + 2'd1;
                    if (pre_cnt_q == 2'd3) begin
                        state_q   <= ST_DATA;
                        bit_cnt_q <= '0;
                        half_q    <= 1'b0;
                        par_q     <= 1'b0;
                    end
                end
                default: begin
                    if (cells == 2'd1) begin
                        half_q <= ~half_q;
                    end
                    if (bit_done) begin
                        par_q     <= par_q ^ bit_val;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                    if (frame_end) begin
                        // The closing edge of P is the start of the next preamble
                        state_q   <= ST_PRE;
                        pre_cnt_q <= 2'd0;
                        valid_o   <= locked_o;
                        if (good_cnt_q == LOCK_W'(LOCK_COUNT - 1)) begin
                            locked_o <= 1'b1;
                        end else begin
                            good_cnt_q <= good_cnt_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk245760) begin
        if (edge_det && state_q == ST_PRE) begin
            if (pre_cnt_q == 2'd1) begin
                pre_w_q[3:2] <= cells;
            end
            if (pre_cnt_q == 2'd2) begin
                pre_w_q[1:0] <= cells;
            end
            if (pre_cnt_q == 2'd3) begin
                pre_type_q <= pre_kind;
            end
        end
        if (bit_done && state_q == ST_DATA) begin
            shreg_q <= shift_next;
        end
        if (frame_end && state_q == ST_DATA) begin
            sample_o <= shift_next[$bits(sample_t)-1:0];
            right_o  <= pre_type_q == PRE_W;
        end
    end

endmodule

// File: stereo_frame_fifo.sv
`timescale 1ns/100ps

module stereo_frame_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic              clk245760,
    input  logic              rst,
    input  dmix_pkg::sample_t sample_i,
    input  logic              right_i,
    input  logic              valid_i,
    input  logic              ready_i,
    output logic              ready_o,
    output dmix_pkg::frame_t  frame_o,
    output logic              valid_o
);
    import dmix_pkg::*;

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    frame_t                   mem [DEPTH];
    logic [FIFO_DEPTH_LOG2:0] wr_ptr_q;
    logic [FIFO_DEPTH_LOG2:0] rd_ptr_q;
    sample_t                  left_q;
    logic                     left_pend_q;
    logic                     full;
    logic                     empty;
    logic                     accept;
    logic                     push;
    logic                     pop;

    // Extra pointer bit tells full from empty
    assign full  = (wr_ptr_q[FIFO_DEPTH_LOG2] != rd_ptr_q[FIFO_DEPTH_LOG2]) &&
                   (wr_ptr_q[FIFO_DEPTH_LOG2-1:0] == rd_ptr_q[FIFO_DEPTH_LOG2-1:0]);
    assign empty = wr_ptr_q == rd_ptr_q;

    assign ready_o = !full;
    assign valid_o = !empty;
    assign frame_o = mem[rd_ptr_q[FIFO_DEPTH_LOG2-1:0]];

    assign accept = valid_i && ready_o;
    // A right sample only completes a pair behind a pending left
    assign push   = accept && right_i && left_pend_q;
    assign pop    = ready_i && valid_o;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            left_pend_q <= 1'b0;
        end else begin
            if (accept) begin
                left_pend_q <= !right_i;
            end
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Newer left overwrites an unpaired one
    always_ff @(posedge clk245760) begin
        if (accept && !right_i) begin
            left_q <= sample_i;
        end
        if (push) begin
            mem[wr_ptr_q[FIFO_DEPTH_LOG2-1:0]] <= {left_q, sample_i};
        end
    end

endmodule

// File: i2s_dac_driver.sv
`timescale 1ns/100ps

module i2s_dac_driver #(
    parameter int BCK_HALF = 4
) (
    input  logic             clk245760,
    input  logic             rst,
    input  dmix_pkg::frame_t frame_i,
    input  logic             valid_i,
    output logic             ready_o,
    output logic             dac_bck_o,
    output logic             dac_lrck_o,
    output logic             dac_data_o
);
    import dmix_pkg::*;

    localparam int WORD_BITS = 2 * SLOT_BITS;
    localparam int BIT_W     = $clog2(WORD_BITS);
    localparam int DIV_W     = $clog2(BCK_HALF + 1);
    localparam int SMP_BITS  = $bits(sample_t);

    logic [DIV_W-1:0]     div_q;
    logic [BIT_W-1:0]     bit_q;
    logic [BIT_W-1:0]     bit_next;
    logic [WORD_BITS-1:0] sh_q;
    logic [WORD_BITS-1:0] load_word;
    logic                 bck_tick;
    logic                 bck_fall;
    logic                 frame_start;
    sample_t              left_s;
    sample_t              right_s;

    // I2S slot: one idle bit, sample MSB first, zero padding
    function automatic logic [SLOT_BITS-1:0] to_slot(input sample_t s);
        to_slot = {1'b0, s, {(SLOT_BITS - SMP_BITS - 1){1'b0}}};
    endfunction

    assign bck_tick    = div_q == DIV_W'(BCK_HALF - 1);
    assign bck_fall    = bck_tick && dac_bck_o;
    assign bit_next    = bit_q + 1'b1;
    // Last bit of the right slot wraps into a new left slot
    assign frame_start = bck_fall && (bit_q == '1);
    assign ready_o     = frame_start;

    assign left_s  = frame_i[2*SMP_BITS-1:SMP_BITS];
    assign right_s = frame_i[SMP_BITS-1:0];

    // Silence on underrun
    assign load_word = valid_i ? {to_slot(left_s), to_slot(right_s)} : '0;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            div_q      <= '0;
            bit_q      <= '1;
            dac_bck_o  <= 1'b0;
            dac_lrck_o <= 1'b0;
            dac_data_o <= 1'b0;
        end else begin
            if (bck_tick) begin
                div_q     <= '0;
                dac_bck_o <= ~dac_bck_o;
            end else begin
                div_q <= div_q + 1'b1;
            end
            // Word clock and data move on the falling bit clock edge
            if (bck_fall) begin
                bit_q      <= bit_next;
                dac_lrck_o <= bit_next[BIT_W-1];
                if (frame_start) begin
                    dac_data_o <= load_word[WORD_BITS-1];
                end else begin
                    dac_data_o <= sh_q[WORD_BITS-1];
                end
            end
        end
    end

    always_ff @(posedge clk245760) begin
        if (frame_start) begin
            sh_q <= {load_word[WORD_BITS-2:0], 1'b0};
        end else if (bck_fall) begin
            sh_q <= {sh_q[WORD_BITS-2:0], 1'b0};
        end
    end

endmodule

// File: dmix_top.sv
`timescale 1ns/100ps

module dmix_top #(
    parameter int CELL_CLKS       = 4,
    parameter int LOCK_COUNT      = 8,
    parameter int FIFO_DEPTH_LOG2 = 3,
    parameter int BCK_HALF        = 4
) (
    input  logic clk245760,
    input  logic rst,
    input  logic spdif_i,
    output logic dac_bck_o,
    output logic dac_lrck_o,
    output logic dac_data_o,
    output logic led_o
);
    import dmix_pkg::*;

    logic [3:0] rst_cnt_q;
    logic       rst_int_q;

    sample_t    dec_sample;
    logic       dec_right;
    logic       dec_valid;
    logic       dec_locked;

    frame_t     fifo_frame;
    logic       fifo_valid;
    logic       drv_ready;

    // Stages stay in reset for 16 clocks after rst falls
    always_ff @(posedge clk245760) begin
        if (rst) begin
            rst_cnt_q <= '0;
        end else if (rst_cnt_q != 4'hf) begin
            rst_cnt_q <= rst_cnt_q + 4'd1;
        end
    end

    always_ff @(posedge clk245760) begin
        rst_int_q <= rst || (rst_cnt_q != 4'hf);
    end

    spdif_decoder #(
        .CELL_CLKS  (CELL_CLKS),
        .LOCK_COUNT (LOCK_COUNT)
    ) decoder_i (
        .clk245760 (clk245760),
        .rst       (rst_int_q),
        .spdif_i   (spdif_i),
        .sample_o  (dec_sample),
        .right_o   (dec_right),
        .valid_o   (dec_valid),
        .locked_o  (dec_locked)
    );

    // S/PDIF cannot be stalled, the decoder drops what the FIFO refuses
    stereo_frame_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) fifo_i (
        .clk245760 (clk245760),
        .rst       (rst_int_q),
        .sample_i  (dec_sample),
        .right_i   (dec_right),
        .valid_i   (dec_valid),
        .ready_i   (drv_ready),
        .ready_o   (),
        .frame_o   (fifo_frame),
        .valid_o   (fifo_valid)
    );

    i2s_dac_driver #(
        .BCK_HALF (BCK_HALF)
    ) driver_i (
        .clk245760  (clk245760),
        .rst        (rst_int_q),
        .frame_i    (fifo_frame),
        .valid_i    (fifo_valid),
        .ready_o    (drv_ready),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o)
    );

    assign led_o = dec_locked;

endmodule

// File: tb_spdif_tx.sv
`timescale 1ns/100ps

module tb_spdif_tx #(
    parameter int CELL_CLKS = 4
) (
    input  logic clk245760,
    output logic spdif_o
);
    import dmix_pkg::*;

    int frame_cnt = 0;

    initial begin
        spdif_o = 1'b0;
    end

    // One transition, then the line holds for a number of cells
    // Entered and left on a falling clock edge
    task automatic pulse(input int cells);
        spdif_o = ~spdif_o;
        repeat (cells * CELL_CLKS) @(negedge clk245760);
    endtask

    // Preamble, then aux+audio LSB first, V, U, C and even parity
    task automatic send_subframe(input logic [23:0] s, input preamble_t pre, input logic bad_par);
        logic [27:0] slots;
        slots = {^s ^ bad_par, 3'b000, s};
        pulse(3);
        case (pre)
            PRE_B: begin
                pulse(1);
                pulse(1);
                pulse(3);
            end
            PRE_M: begin
                pulse(3);
                pulse(1);
                pulse(1);
            end
            default: begin
                pulse(2);
                pulse(1);
                pulse(2);
            end
        endcase
        for (int i = 0; i < 28; i++) begin
            if (slots[i]) begin
                pulse(1);
                pulse(1);
            end else begin
                pulse(2);
            end
        end
    endtask

    // Left in the upper half, a B preamble every 192 frames
    task automatic send_frame(input logic [47:0] f, input logic bad_right);
        send_subframe(f[47:24], (frame_cnt % 192 == 0) ? PRE_B : PRE_M, 1'b0);
        send_subframe(f[23:0], PRE_W, bad_right);
        frame_cnt++;
    endtask

    // The first edge closes the last parity bit, then the line goes quiet
    task automatic send_silence(input int cells);
        pulse(cells);
    endtask

endmodule

// File: tb_dmix_top.sv
`timescale 1ns/100ps

module tb_dmix_top;

    logic        clk245760;
    logic        rst;
    logic        spdif;
    logic        dac_bck_o;
    logic        dac_lrck_o;
    logic        dac_data_o;
    logic        led_o;

    logic [47:0] sent_q[$];
    string       test_name = "reset";
    longint      cycle = 0;
    longint      led_rise_cycle = 0;
    longint      led_fall_cycle = 0;
    int          led_falls = 0;
    logic        led_q = 1'b0;
    int          zero_frames = 0;
    int          bck_rises = 0;
    logic [31:0] left_sh = '0;
    logic [31:0] right_sh = '0;
    int          left_cnt = 0;
    int          right_cnt = 0;
    logic        lr_prev = 1'b0;

    dmix_top dut_i (
        .clk245760  (clk245760),
        .rst        (rst),
        .spdif_i    (spdif),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o),
        .led_o      (led_o)
    );

    tb_spdif_tx tx_i (
        .clk245760 (clk245760),
        .spdif_o   (spdif)
    );

    initial begin
        clk245760 = 1'b0;
        forever #4 clk245760 = ~clk245760;
    end

    task automatic report_mismatch(input string test, input logic [47:0] exp,
                                   input logic [47:0] act);
        $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
        $display("** FAIL **");
        $fatal(1, "value check failed");
    endtask

    task automatic report_problem(input string what);
        $display("Failure: %s", what);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    // Lock edges and a cycle count for the timing checks
    always @(posedge clk245760) begin
        cycle++;
        if (led_o && !led_q) begin
            led_rise_cycle = cycle;
        end
        if (!led_o && led_q) begin
            led_fall_cycle = cycle;
            led_falls++;
        end
        led_q <= led_o;
    end

    // Each slot holds an idle bit, 24 sample bits and 7 zero bits
    task automatic check_frame(input logic [31:0] ls, input logic [31:0] rs);
        logic [47:0] got;
        logic [47:0] exp;
        got = {ls[30:7], rs[30:7]};
        assert ({ls[31], ls[6:0], rs[31], rs[6:0]} == 16'h0)
            else report_mismatch("slot padding", 48'h0,
                                 48'({ls[31], ls[6:0], rs[31], rs[6:0]}));
        if (got == 48'h0) begin
            zero_frames++;
        end else begin
            assert (sent_q.size() != 0)
                else report_problem("a non-zero frame was played that was never sent");
            exp = sent_q.pop_front();
            assert (got == exp) else report_mismatch(test_name, exp, got);
        end
    endtask

    // Data is stable at the rising bit clock
    // lrck low marks the left slot
    always @(posedge dac_bck_o) begin
        if (!dac_lrck_o && lr_prev) begin
            if (left_cnt == 32 && right_cnt == 32) begin
                check_frame(left_sh, right_sh);
            end
            left_cnt  = 0;
            right_cnt = 0;
        end
        if (dac_lrck_o) begin
            right_sh = {right_sh[30:0], dac_data_o};
            right_cnt++;
        end else begin
            left_sh = {left_sh[30:0], dac_data_o};
            left_cnt++;
        end
        lr_prev = dac_lrck_o;
        bck_rises++;
    end

    function automatic logic [23:0] random_sample();
        logic [23:0] s;
        s = 24'h0;
        while (s == 24'h0) begin
            s = 24'($urandom);
        end
        return s;
    endfunction

    task automatic send_random(input int count);
        logic [47:0] f;
        repeat (count) begin
            f = {random_sample(), random_sample()};
            sent_q.push_back(f);
            tx_i.send_frame(f, 1'b0);
        end
    endtask

    // Lock must drop about 4 cells after the last edge
    task automatic stop_source();
        longint start;
        longint delay;
        start = cycle;
        tx_i.send_silence(8);
        delay = led_fall_cycle - start;
        assert (!led_o && delay >= 16 && delay <= 26)
            else report_mismatch("lock drop", 48'd20, 48'(delay));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (sent_q.size() != 0) begin
            @(negedge clk245760);
            n++;
            if (n > 16 * 512) begin
                report_problem("sent frames did not all play out");
            end
        end
    endtask

    task automatic wait_zero_frames(input int count);
        int n;
        n = 0;
        while (zero_frames < count) begin
            @(negedge clk245760);
            n++;
            if (n > (count + 2) * 512) begin
                report_problem("no silent frames played after reset");
            end
        end
    endtask

    task automatic wait_lrck_fall(output int clocks);
        logic prev;
        logic seen;
        prev   = dac_lrck_o;
        seen   = 1'b0;
        clocks = 0;
        while (!seen) begin
            @(negedge clk245760);
            clocks++;
            seen = prev && !dac_lrck_o;
            prev = dac_lrck_o;
            if (clocks > 1024) begin
                report_problem("word clock stopped toggling");
            end
        end
    endtask

    initial begin
        longint rise;
        int     falls;
        int     n;
        int     rises;
        int     zeros;
        void'($urandom(87679));
        rst = 1'b1;
        repeat (5) @(posedge clk245760);
        @(negedge clk245760);
        rst = 1'b0;
        repeat (16) begin
            @(negedge clk245760);
            assert ({dac_bck_o, dac_lrck_o, dac_data_o, led_o} == 4'b0)
                else report_mismatch(test_name, 48'h0,
                                     48'({dac_bck_o, dac_lrck_o, dac_data_o, led_o}));
        end
        wait_zero_frames(3);

        // Silent frames carry the source through lock
        test_name = "lock";
        rise = cycle;
        repeat (5) tx_i.send_frame(48'h0, 1'b0);
        rise = led_rise_cycle - rise;
        assert (led_o && rise >= 8 * 256 && rise <= 9 * 256)
            else report_mismatch(test_name, 48'd2048, 48'(rise));

        test_name = "data path";
        send_random(40);
        stop_source();
        wait_drain();

        test_name = "parity fault";
        repeat (5) tx_i.send_frame(48'h0, 1'b0);
        assert (led_o) else report_problem("decoder did not lock before the parity test");
        send_random(4);
        falls = led_falls;
        tx_i.send_frame({random_sample(), random_sample()}, 1'b1);
        repeat (7) tx_i.send_frame(48'h0, 1'b0);
        assert (led_falls == falls + 1 && led_o)
            else report_problem("lock did not drop and recover around the parity error");
        send_random(10);
        stop_source();
        wait_drain();

        test_name = "underrun";
        zeros = zero_frames;
        wait_lrck_fall(n);
        repeat (4) begin
            rises = bck_rises;
            wait_lrck_fall(n);
            assert (n == 512) else report_mismatch("underrun frame length", 48'd512, 48'(n));
            assert (bck_rises - rises == 64)
                else report_mismatch("underrun bit clocks", 48'd64, 48'(bck_rises - rises));
        end
        assert (zero_frames >= zeros + 3)
            else report_mismatch(test_name, 48'(zeros + 3), 48'(zero_frames));

        $display("** PASS **");
        $finish;
    end

endmodule

// File: vlog.f
dmix_pkg.sv
spdif_decoder.sv
stereo_frame_fifo.sv
i2s_dac_driver.sv
dmix_top.sv
tb_spdif_tx.sv
tb_dmix_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_dmix_top -o sim_tb

# The simulator status is not trusted, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
